// ==== dual_mem_stage.f ====
logic/mem_stage_pkg.sv
logic/mem_port_if.sv
logic/slot_if.sv
logic/mem_request_select.sv
logic/memory_stage.sv
logic/data_scratchpad.sv
logic/load_align_unit.sv
logic/writeback_stage.sv
logic/dual_mem_top.sv
verification/dual_mem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --top-module dual_mem_tb -f dual_mem_stage.f &&
./obj_dir/Vdual_mem_tb > sim.log 2>&1
grep -qx "test passed" sim.log && echo "simulation ok" || { echo "simulation FAILED"; exit 1; }

// ==== verification/dual_mem_tb.sv ====
`timescale 1ns/1ps

module dual_mem_tb;
  import mem_stage_pkg::*;

  localparam int MEM_DEPTH = 256;
  localparam int WAIT_STATES = 2;
  localparam int NUM_PAIRS = 38;               // Pairs issued over all tests.
  localparam int PAIR_CYCLES = WAIT_STATES + 6;
  localparam int CYCLE_LIMIT = NUM_PAIRS * PAIR_CYCLES + 20;

  logic clock;
  logic reset;
  logic issue;
  logic clear;
  mem_op_t slot0_op;
  size_t slot0_size;
  logic slot0_unsigned;
  addr_t slot0_addr;
  xlen_t slot0_value;
  reg_addr_t slot0_waddr;
  logic slot0_wren;
  mem_op_t slot1_op;
  size_t slot1_size;
  logic slot1_unsigned;
  addr_t slot1_addr;
  xlen_t slot1_value;
  reg_addr_t slot1_waddr;
  logic slot1_wren;
  logic stall;
  logic fwd0_wren;
  reg_addr_t fwd0_waddr;
  xlen_t fwd0_wdata;
  logic fwd1_wren;
  reg_addr_t fwd1_waddr;
  xlen_t fwd1_wdata;
  logic retire0_wren;
  reg_addr_t retire0_waddr;
  xlen_t retire0_wdata;
  logic retire1_wren;
  reg_addr_t retire1_waddr;
  xlen_t retire1_wdata;

  xlen_t ref_mem [MEM_DEPTH]; // Mirror of the scratchpad.
  logic [31:0] lcg_state;
  int cycles;

  dual_mem_top #(
    .MEM_DEPTH(MEM_DEPTH),
    .WAIT_STATES(WAIT_STATES)
  ) DUT (.*);

  always #4 clock = ~clock;

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the tests did not finish within %0d cycles.", CYCLE_LIMIT);
      $display("test failed");
      $fatal(1, "Simulation stopped by the cycle limit.");
    end
  end

  function automatic xlen_t next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic xlen_t extract_load(xlen_t word, size_t size, logic unsigned_load,
                                         logic [1:0] offset);
    xlen_t shifted;
    shifted = word >> {offset, 3'b000};
    case (size)
      size_byte: begin
        shifted = shifted & 32'h0000_00ff;
        if (!unsigned_load && shifted[7]) shifted = shifted | 32'hffff_ff00;
      end
      size_half: begin
        shifted = shifted & 32'h0000_ffff;
        if (!unsigned_load && shifted[15]) shifted = shifted | 32'hffff_0000;
      end
      default: shifted = word;
    endcase
    return shifted;
  endfunction

  function automatic void apply_store(addr_t addr, size_t size, xlen_t value);
    xlen_t mask;
    case (size)
      size_byte: mask = 32'h0000_00ff;
      size_half: mask = 32'h0000_ffff;
      default: mask = 32'hffff_ffff;
    endcase
    mask = mask << {addr[1:0], 3'b000};
    ref_mem[addr[9:2]] = (ref_mem[addr[9:2]] & ~mask) | ((value << {addr[1:0], 3'b000}) & mask);
  endfunction

  task check_value(input string name, input xlen_t expected, input xlen_t actual);
    if (actual !== expected) begin
      $display("FAILED %s expected %h actual %h", name, expected, actual);
      $display("test failed");
      $fatal(1, "Stopping at the first mismatch.");
    end
  endtask

  task drive_slot(input int n, input mem_op_t op, input size_t size, input logic uns,
                  input addr_t addr, input xlen_t value, input reg_addr_t waddr,
                  input logic wren);
    if (n == 0) begin
      slot0_op <= op;
      slot0_size <= size;
      slot0_unsigned <= uns;
      slot0_addr <= addr;
      slot0_value <= value;
      slot0_waddr <= waddr;
      slot0_wren <= wren;
    end else begin
      slot1_op <= op;
      slot1_size <= size;
      slot1_unsigned <= uns;
      slot1_addr <= addr;
      slot1_value <= value;
      slot1_waddr <= waddr;
      slot1_wren <= wren;
    end
  endtask

  // Holds issue until the pair is taken on a rising edge.
  task accept_pair();
    issue <= 1'b1;
    @(negedge clock);
    while (stall) @(negedge clock);
    @(posedge clock);
    issue <= 1'b0;
  endtask

  task run_pair(input logic exp0_wren, input xlen_t exp0_data, input logic exp1_wren,
                input xlen_t exp1_data, input int exp_stalls);
    int stalls;
    logic seen0_wren;
    logic seen1_wren;
    reg_addr_t seen0_waddr;
    reg_addr_t seen1_waddr;
    xlen_t seen0_wdata;
    xlen_t seen1_wdata;
    accept_pair();
    stalls = 0;
    @(negedge clock);
    while (stall) begin
      stalls++;
      @(negedge clock);
    end
    check_value("stall cycles", xlen_t'(exp_stalls), xlen_t'(stalls));
    check_value("fwd0_wren", xlen_t'(exp0_wren), xlen_t'(fwd0_wren));
    check_value("fwd1_wren", xlen_t'(exp1_wren), xlen_t'(fwd1_wren));
    if (exp0_wren) begin
      check_value("fwd0_waddr", xlen_t'(slot0_waddr), xlen_t'(fwd0_waddr));
      check_value("fwd0_wdata", exp0_data, fwd0_wdata);
    end
    if (exp1_wren) begin
      check_value("fwd1_waddr", xlen_t'(slot1_waddr), xlen_t'(fwd1_waddr));
      check_value("fwd1_wdata", exp1_data, fwd1_wdata);
    end
    seen0_wren = fwd0_wren;
    seen1_wren = fwd1_wren;
    seen0_waddr = fwd0_waddr;
    seen1_waddr = fwd1_waddr;
    seen0_wdata = fwd0_wdata;
    seen1_wdata = fwd1_wdata;
    @(negedge clock); // Retire follows one cycle later.
    check_value("retire0_wren", xlen_t'(seen0_wren), xlen_t'(retire0_wren));
    check_value("retire0_waddr", xlen_t'(seen0_waddr), xlen_t'(retire0_waddr));
    check_value("retire0_wdata", seen0_wdata, retire0_wdata);
    check_value("retire1_wren", xlen_t'(seen1_wren), xlen_t'(retire1_wren));
    check_value("retire1_waddr", xlen_t'(seen1_waddr), xlen_t'(retire1_waddr));
    check_value("retire1_wdata", seen1_wdata, retire1_wdata);
  endtask

  task store_pair(input int slot, input size_t size, input addr_t addr, input xlen_t value);
    xlen_t other;
    other = next_random();
    @(posedge clock);
    drive_slot(slot, op_store, size, 1'b0, addr, value, 5'd0, 1'b0);
    drive_slot(1 - slot, op_none, size_word, 1'b0, 32'd0, other, 5'd5, 1'b1);
    if (slot == 0) run_pair(1'b0, 32'd0, 1'b1, other, WAIT_STATES);
    else run_pair(1'b1, other, 1'b0, 32'd0, WAIT_STATES);
    apply_store(addr, size, value);
  endtask

  task load_pair(input int slot, input size_t size, input logic uns, input addr_t addr);
    xlen_t expected;
    xlen_t other;
    expected = extract_load(ref_mem[addr[9:2]], size, uns, addr[1:0]);
    other = next_random();
    @(posedge clock);
    drive_slot(slot, op_load, size, uns, addr, 32'd0, 5'd3, 1'b1);
    drive_slot(1 - slot, op_none, size_word, 1'b0, 32'd0, other, 5'd9, 1'b1);
    if (slot == 0) run_pair(1'b1, expected, 1'b1, other, WAIT_STATES);
    else run_pair(1'b1, other, 1'b1, expected, WAIT_STATES);
  endtask

  task reset_and_plain_pair();
    xlen_t v0;
    xlen_t v1;
    check_value("stall", 32'd0, xlen_t'(stall));
    check_value("fwd0_wren", 32'd0, xlen_t'(fwd0_wren));
    check_value("fwd1_wren", 32'd0, xlen_t'(fwd1_wren));
    check_value("retire0_wren", 32'd0, xlen_t'(retire0_wren));
    check_value("retire1_wren", 32'd0, xlen_t'(retire1_wren));
    v0 = next_random();
    v1 = next_random();
    @(posedge clock);
    drive_slot(0, op_none, size_word, 1'b0, 32'd0, v0, 5'd1, 1'b1);
    drive_slot(1, op_none, size_word, 1'b0, 32'd0, v1, 5'd2, 1'b1);
    run_pair(1'b1, v0, 1'b1, v1, 0);
  endtask

  task store_sizes();
    addr_t addr;
    xlen_t pick;
    for (int s = 0; s < 3; s++) begin
      pick = next_random();
      addr = {22'd0, pick[9:2], 2'b00};
      store_pair(s % 2, size_word, addr, next_random()); // Known fill around the lane.
      if (s == 0) addr[1:0] = pick[11:10];
      if (s == 1) addr[1] = pick[10];
      store_pair(s % 2, size_t'(s), addr, next_random());
      load_pair((s + 1) % 2, size_word, 1'b0, {addr[31:2], 2'b00});
    end
  endtask

  task narrow_loads();
    store_pair(0, size_word, 32'h40, 32'h8001_7ffe); // Mixed sign bits per lane.
    for (int slot = 0; slot < 2; slot++) begin
      for (int uns = 0; uns < 2; uns++) begin
        for (int off = 0; off < 4; off++) begin
          load_pair(slot, size_byte, uns[0], 32'h40 + off);
          if (off % 2 == 0) load_pair(slot, size_half, uns[0], 32'h40 + off);
        end
      end
    end
  endtask

  task fence_squash();
    xlen_t v0;
    xlen_t v1;
    v0 = next_random();
    v1 = next_random();
    @(posedge clock);
    drive_slot(0, op_fence, size_word, 1'b0, 32'h80, v0, 5'd12, 1'b1);
    drive_slot(1, op_none, size_word, 1'b0, 32'd0, v1, 5'd13, 1'b1);
    run_pair(1'b1, v0, 1'b0, 32'd0, WAIT_STATES);
  endtask

  task clear_during_load();
    @(posedge clock);
    drive_slot(0, op_load, size_word, 1'b0, 32'h40, 32'd0, 5'd20, 1'b1);
    drive_slot(1, op_none, size_word, 1'b0, 32'd0, 32'h1234, 5'd21, 1'b1);
    accept_pair();
    clear <= 1'b1; // Flush in the first stalled cycle.
    @(negedge clock);
    check_value("stall", 32'd1, xlen_t'(stall));
    check_value("fwd0_wren", 32'd0, xlen_t'(fwd0_wren));
    @(posedge clock);
    clear <= 1'b0;
    @(negedge clock);
    check_value("stall", 32'd1, xlen_t'(stall)); // Load still out.
    while (stall) @(negedge clock); // Drain of the flushed load.
    repeat (3) begin
      check_value("fwd0_wren", 32'd0, xlen_t'(fwd0_wren));
      check_value("fwd1_wren", 32'd0, xlen_t'(fwd1_wren));
      check_value("retire0_wren", 32'd0, xlen_t'(retire0_wren));
      check_value("retire1_wren", 32'd0, xlen_t'(retire1_wren));
      @(negedge clock);
    end
    load_pair(0, size_word, 1'b0, 32'h40);
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b0;
    issue = 1'b0;
    clear = 1'b0;
    drive_slot(0, op_none, size_word, 1'b0, 32'd0, 32'd0, 5'd0, 1'b0);
    drive_slot(1, op_none, size_word, 1'b0, 32'd0, 32'd0, 5'd0, 1'b0);
    lcg_state = 32'he9c4_4eb3;
    cycles = 0;
    for (int i = 0; i < MEM_DEPTH; i++) begin
      ref_mem[i] = '0;
    end
    repeat (3) @(posedge clock);
    reset <= 1'b1;
    @(negedge clock);
    reset_and_plain_pair();
    store_sizes();
    narrow_loads();
    fence_squash();
    clear_during_load();
    $display("test passed");
    $finish;
  end

endmodule

// ==== logic/dual_mem_top.sv ====
`timescale 1ns/1ps

module dual_mem_top #(
  parameter int MEM_DEPTH = 256,
  parameter int WAIT_STATES = 0
) (
  input logic clock,
  input logic reset,
  input logic issue,
  input logic clear,
  input mem_stage_pkg::mem_op_t slot0_op,
  input mem_stage_pkg::size_t slot0_size,
  input logic slot0_unsigned,
  input mem_stage_pkg::addr_t slot0_addr,
  input mem_stage_pkg::xlen_t slot0_value,
  input mem_stage_pkg::reg_addr_t slot0_waddr,
  input logic slot0_wren,
  input mem_stage_pkg::mem_op_t slot1_op,
  input mem_stage_pkg::size_t slot1_size,
  input logic slot1_unsigned,
  input mem_stage_pkg::addr_t slot1_addr,
  input mem_stage_pkg::xlen_t slot1_value,
  input mem_stage_pkg::reg_addr_t slot1_waddr,
  input logic slot1_wren,
  output logic stall,
  output logic fwd0_wren,
  output mem_stage_pkg::reg_addr_t fwd0_waddr,
  output mem_stage_pkg::xlen_t fwd0_wdata,
  output logic fwd1_wren,
  output mem_stage_pkg::reg_addr_t fwd1_waddr,
  output mem_stage_pkg::xlen_t fwd1_wdata,
  output logic retire0_wren,
  output mem_stage_pkg::reg_addr_t retire0_waddr,
  output mem_stage_pkg::xlen_t retire0_wdata,
  output logic retire1_wren,
  output mem_stage_pkg::reg_addr_t retire1_waddr,
  output mem_stage_pkg::xlen_t retire1_wdata
);

  mem_port_if mem ();
  slot_if slot0 ();
  slot_if slot1 ();

  mem_request_select request (
    .issue(issue),
    .stall(stall),
    .clear(clear),
    .slot0_op(slot0_op),
    .slot0_size(slot0_size),
    .slot0_addr(slot0_addr),
    .slot0_value(slot0_value),
    .slot1_op(slot1_op),
    .slot1_size(slot1_size),
    .slot1_addr(slot1_addr),
    .slot1_value(slot1_value),
    .port(mem.requester)
  );

  memory_stage stage (
    .clock(clock),
    .reset(reset),
    .issue(issue),
    .clear(clear),
    .slot0_op(slot0_op),
    .slot0_size(slot0_size),
    .slot0_unsigned(slot0_unsigned),
    .slot0_offset(slot0_addr[1:0]),
    .slot0_value(slot0_value),
    .slot0_waddr(slot0_waddr),
    .slot0_wren(slot0_wren),
    .slot1_op(slot1_op),
    .slot1_size(slot1_size),
    .slot1_unsigned(slot1_unsigned),
    .slot1_offset(slot1_addr[1:0]),
    .slot1_value(slot1_value),
    .slot1_waddr(slot1_waddr),
    .slot1_wren(slot1_wren),
    .stall(stall),
    .mem(mem.observer),
    .slot0(slot0.master),
    .slot1(slot1.master)
  );

  data_scratchpad #(
    .MEM_DEPTH(MEM_DEPTH),
    .WAIT_STATES(WAIT_STATES)
  ) scratchpad (
    .clock(clock),
    .reset(reset),
    .port(mem.responder)
  );

  writeback_stage writeback (
    .clock(clock),
    .reset(reset),
    .mem(mem.observer),
    .slot0(slot0.reader),
    .slot1(slot1.reader),
    .fwd0_wren(fwd0_wren),
    .fwd0_waddr(fwd0_waddr),
    .fwd0_wdata(fwd0_wdata),
    .fwd1_wren(fwd1_wren),
    .fwd1_waddr(fwd1_waddr),
    .fwd1_wdata(fwd1_wdata),
    .retire0_wren(retire0_wren),
    .retire0_waddr(retire0_waddr),
    .retire0_wdata(retire0_wdata),
    .retire1_wren(retire1_wren),
    .retire1_waddr(retire1_waddr),
    .retire1_wdata(retire1_wdata)
  );

endmodule

// ==== logic/writeback_stage.sv ====
`timescale 1ns/1ps

module writeback_stage (
  input logic clock,
  input logic reset,
  mem_port_if.observer mem,
  slot_if.reader slot0,
  slot_if.reader slot1,
  output logic fwd0_wren,
  output mem_stage_pkg::reg_addr_t fwd0_waddr,
  output mem_stage_pkg::xlen_t fwd0_wdata,
  output logic fwd1_wren,
  output mem_stage_pkg::reg_addr_t fwd1_waddr,
  output mem_stage_pkg::xlen_t fwd1_wdata,
  output logic retire0_wren,
  output mem_stage_pkg::reg_addr_t retire0_waddr,
  output mem_stage_pkg::xlen_t retire0_wdata,
  output logic retire1_wren,
  output mem_stage_pkg::reg_addr_t retire1_waddr,
  output mem_stage_pkg::xlen_t retire1_wdata
);
  import mem_stage_pkg::*;

  xlen_t load0;
  xlen_t load1;

  load_align_unit align0 (
    .rdata(mem.rdata),
    .size(slot0.size),
    .unsigned_load(slot0.unsigned_load),
    .offset(slot0.offset),
    .result(load0)
  );

  load_align_unit align1 (
    .rdata(mem.rdata),
    .size(slot1.size),
    .unsigned_load(slot1.unsigned_load),
    .offset(slot1.offset),
    .result(load1)
  );

  assign fwd0_wren = slot0.wren & slot0.complete;
  assign fwd0_waddr = slot0.waddr;
  assign fwd0_wdata = slot0.is_load ? load0 : slot0.value;

  assign fwd1_wren = slot1.wren & slot1.complete;
  assign fwd1_waddr = slot1.waddr;
  assign fwd1_wdata = slot1.is_load ? load1 : slot1.value;

  always_ff @(posedge clock) begin
    if (!reset) begin
      retire0_wren <= 1'b0;
      retire1_wren <= 1'b0;
    end else begin
      retire0_wren <= fwd0_wren;
      retire1_wren <= fwd1_wren;
    end
  end

  always_ff @(posedge clock) begin
    retire0_waddr <= fwd0_waddr;
    retire0_wdata <= fwd0_wdata;
    retire1_waddr <= fwd1_waddr;
    retire1_wdata <= fwd1_wdata;
  end

endmodule

// ==== logic/load_align_unit.sv ====
`timescale 1ns/1ps

module load_align_unit (
  input mem_stage_pkg::xlen_t rdata,
  input mem_stage_pkg::size_t size,
  input logic unsigned_load,
  input logic [1:0] offset,
  output mem_stage_pkg::xlen_t result
);
  import mem_stage_pkg::*;

  logic [7:0] byte_data;
  logic [15:0] half_data;

  assign byte_data = rdata[8*offset +: 8];
  assign half_data = offset[1] ? rdata[31:16] : rdata[15:0];

  always_comb begin
    case (size)
      size_byte: begin
        result = {{24{byte_data[7] & ~unsigned_load}}, byte_data};
      end
      size_half: begin
        result = {{16{half_data[15] & ~unsigned_load}}, half_data};
      end
      default: result = rdata; // Word as is.
    endcase
  end

endmodule

// ==== logic/data_scratchpad.sv ====
`timescale 1ns/1ps

module data_scratchpad #(
  parameter int MEM_DEPTH = 256,
  parameter int WAIT_STATES = 0
) (
  input logic clock,
  input logic reset,
  mem_port_if.responder port
);
  import mem_stage_pkg::*;

  localparam int IDX_W = $clog2(MEM_DEPTH);
  localparam int CNT_W = (WAIT_STATES > 1) ? $clog2(WAIT_STATES) : 1;

  scratch_state_e state_q;
  logic [CNT_W-1:0] count_q;
  logic fence_q;
  addr_t addr_q;
  xlen_t wdata_q;
  strobe_t wstrb_q;
  logic [IDX_W-1:0] index;
  xlen_t mem [MEM_DEPTH];

  initial begin
    for (int i = 0; i < MEM_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  assign index = addr_q[IDX_W+1:2];

  always_ff @(posedge clock) begin
    if (!reset) begin
      state_q <= idle;
      count_q <= '0;
    end else begin
      case (state_q)
        idle, respond: begin
          count_q <= '0;
          if (port.valid) begin
            state_q <= (WAIT_STATES == 0) ? respond : waiting;
          end else begin
            state_q <= idle;
          end
        end
        waiting: begin
          if (count_q == CNT_W'(WAIT_STATES - 1)) begin
            state_q <= respond;
          end else begin
            count_q <= count_q + 1'b1;
          end
        end
        default: state_q <= idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (port.valid) begin // Only seen when idle or responding.
      fence_q <= port.fence;
      addr_q <= port.addr;
      wdata_q <= port.wdata;
      wstrb_q <= port.wstrb;
    end
  end

  always @(posedge clock) begin
    if (state_q == respond && !fence_q) begin
      for (int b = 0; b < 4; b++) begin
        if (wstrb_q[b]) mem[index][8*b +: 8] <= wdata_q[8*b +: 8];
      end
    end
  end

  assign port.rdata = mem[index];
  assign port.ready = (state_q == respond);

endmodule

// ==== logic/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage (
  input logic clock,
  input logic reset,
  input logic issue,
  input logic clear,
  input mem_stage_pkg::mem_op_t slot0_op,
  input mem_stage_pkg::size_t slot0_size,
  input logic slot0_unsigned,
  input logic [1:0] slot0_offset,
  input mem_stage_pkg::xlen_t slot0_value,
  input mem_stage_pkg::reg_addr_t slot0_waddr,
  input logic slot0_wren,
  input mem_stage_pkg::mem_op_t slot1_op,
  input mem_stage_pkg::size_t slot1_size,
  input logic slot1_unsigned,
  input logic [1:0] slot1_offset,
  input mem_stage_pkg::xlen_t slot1_value,
  input mem_stage_pkg::reg_addr_t slot1_waddr,
  input logic slot1_wren,
  output logic stall,
  mem_port_if.observer mem,
  slot_if.master slot0,
  slot_if.master slot1
);
  import mem_stage_pkg::*;

  logic accept;
  logic squash;
  logic full_q;
  logic busy_q;  // Live pair waits for its access.
  logic drain_q; // Access of a flushed pair is still out.
  logic complete;

  logic slot0_wren_q;
  logic slot1_wren_q;
  reg_addr_t slot0_waddr_q;
  reg_addr_t slot1_waddr_q;
  xlen_t slot0_value_q;
  xlen_t slot1_value_q;
  logic slot0_load_q;
  logic slot1_load_q;
  size_t slot0_size_q;
  size_t slot1_size_q;
  logic slot0_unsigned_q;
  logic slot1_unsigned_q;
  logic [1:0] slot0_offset_q;
  logic [1:0] slot1_offset_q;

  assign stall = (busy_q | drain_q) & ~mem.ready;
  assign accept = issue & ~stall & ~clear;
  assign squash = (slot0_op == op_fence); // Fence kills its partner.
  assign complete = full_q & ~stall & ~clear;

  always_ff @(posedge clock) begin
    if (!reset) begin
      full_q <= 1'b0;
      busy_q <= 1'b0;
      drain_q <= 1'b0;
      slot0_wren_q <= 1'b0;
      slot1_wren_q <= 1'b0;
    end else begin
      if (mem.valid) begin
        busy_q <= 1'b1;
      end else if (mem.ready | clear) begin
        busy_q <= 1'b0;
      end
      if (clear & busy_q & ~mem.ready) begin
        drain_q <= 1'b1;
      end else if (mem.ready) begin
        drain_q <= 1'b0;
      end
      if (clear) begin
        full_q <= 1'b0;
        slot0_wren_q <= 1'b0;
        slot1_wren_q <= 1'b0;
      end else if (accept) begin
        full_q <= 1'b1;
        slot0_wren_q <= slot0_wren;
        slot1_wren_q <= slot1_wren & ~squash;
      end else if (complete) begin
        full_q <= 1'b0;
      end
    end
  end

  // Payload follows the accepted pair.
  always_ff @(posedge clock) begin
    if (accept) begin
      slot0_waddr_q <= slot0_waddr;
      slot0_value_q <= slot0_value;
      slot0_load_q <= (slot0_op == op_load);
      slot0_size_q <= slot0_size;
      slot0_unsigned_q <= slot0_unsigned;
      slot0_offset_q <= slot0_offset;
      slot1_waddr_q <= slot1_waddr;
      slot1_value_q <= slot1_value;
      slot1_load_q <= (slot1_op == op_load) & ~squash;
      slot1_size_q <= slot1_size;
      slot1_unsigned_q <= slot1_unsigned;
      slot1_offset_q <= slot1_offset;
    end
  end

  assign slot0.wren = slot0_wren_q & full_q;
  assign slot0.waddr = slot0_waddr_q;
  assign slot0.value = slot0_value_q;
  assign slot0.is_load = slot0_load_q;
  assign slot0.size = slot0_size_q;
  assign slot0.unsigned_load = slot0_unsigned_q;
  assign slot0.offset = slot0_offset_q;
  assign slot0.complete = complete;

  assign slot1.wren = slot1_wren_q & full_q;
  assign slot1.waddr = slot1_waddr_q;
  assign slot1.value = slot1_value_q;
  assign slot1.is_load = slot1_load_q;
  assign slot1.size = slot1_size_q;
  assign slot1.unsigned_load = slot1_unsigned_q;
  assign slot1.offset = slot1_offset_q;
  assign slot1.complete = complete;

endmodule

// ==== logic/mem_request_select.sv ====
`timescale 1ns/1ps

module mem_request_select (
  input logic issue,
  input logic stall,
  input logic clear,
  input mem_stage_pkg::mem_op_t slot0_op,
  input mem_stage_pkg::size_t slot0_size,
  input mem_stage_pkg::addr_t slot0_addr,
  input mem_stage_pkg::xlen_t slot0_value,
  input mem_stage_pkg::mem_op_t slot1_op,
  input mem_stage_pkg::size_t slot1_size,
  input mem_stage_pkg::addr_t slot1_addr,
  input mem_stage_pkg::xlen_t slot1_value,
  mem_port_if.requester port
);
  import mem_stage_pkg::*;

  logic accept;
  logic use_slot0;
  mem_op_t sel_op;
  size_t sel_size;
  addr_t sel_addr;
  xlen_t sel_value;

  assign accept = issue & ~stall & ~clear;
  assign use_slot0 = (slot0_op != op_none); // Slot 0 wins.

  assign sel_op = use_slot0 ? slot0_op : slot1_op;
  assign sel_size = use_slot0 ? slot0_size : slot1_size;
  assign sel_addr = use_slot0 ? slot0_addr : slot1_addr;
  assign sel_value = use_slot0 ? slot0_value : slot1_value;

  assign port.valid = accept & (sel_op != op_none);
  assign port.fence = (sel_op == op_fence);
  assign port.addr = sel_addr;

  always_comb begin
    case (sel_size)
      size_byte: port.wdata = {4{sel_value[7:0]}};
      size_half: port.wdata = {2{sel_value[15:0]}};
      default: port.wdata = sel_value;
    endcase
  end

  always_comb begin
    port.wstrb = 4'b0000;
    if (sel_op == op_store) begin
      case (sel_size)
        size_byte: port.wstrb = 4'b0001 << sel_addr[1:0];
        size_half: port.wstrb = sel_addr[1] ? 4'b1100 : 4'b0011;
        default: port.wstrb = 4'b1111;
      endcase
    end
  end

endmodule

// ==== logic/slot_if.sv ====
`timescale 1ns/1ps

interface slot_if;
  import mem_stage_pkg::*;

  logic wren;
  reg_addr_t waddr;
  xlen_t value;
  logic is_load;
  size_t size;
  logic unsigned_load;
  logic [1:0] offset;
  logic complete; // Pair finishes this cycle.

  modport master (output wren, waddr, value, is_load, size, unsigned_load, offset, complete);

  modport reader (input wren, waddr, value, is_load, size, unsigned_load, offset, complete);

endinterface

// ==== logic/mem_port_if.sv ====
`timescale 1ns/1ps

interface mem_port_if;
  import mem_stage_pkg::*;

  logic valid;
  logic fence;
  addr_t addr;
  xlen_t wdata;
  strobe_t wstrb;
  xlen_t rdata;
  logic ready;

  modport requester (output valid, fence, addr, wdata, wstrb);

  modport responder (
    input valid, fence, addr, wdata, wstrb,
    output rdata, ready
  );

  modport observer (input valid, ready, rdata);

endinterface

// ==== logic/mem_stage_pkg.sv ====
package mem_stage_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [3:0] strobe_t;
  typedef logic [1:0] mem_op_t;
  typedef logic [1:0] size_t;

  // Operation codes carried by each slot.
  localparam mem_op_t op_none = 2'd0;
  localparam mem_op_t op_load = 2'd1;
  localparam mem_op_t op_store = 2'd2;
  localparam mem_op_t op_fence = 2'd3;

  // Access sizes.
  localparam size_t size_byte = 2'd0;
  localparam size_t size_half = 2'd1;
  localparam size_t size_word = 2'd2;

  typedef enum logic [1:0] {
    idle,
    waiting,
    respond
  } scratch_state_e;

endpackage
